// ==== Bender.yml ====
package:
  name: imuldiv

sources:
  - src/imuldiv_pkg.sv
  - src/imuldiv_div_dpath.sv
  - src/imuldiv_div_ctrl.sv
  - src/imuldiv_mul_iterative.sv
  - src/imuldiv_unit.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/imuldiv_unit_tb.sv

// ==== imuldiv_unit.f ====
+incdir+test
src/imuldiv_pkg.sv
src/imuldiv_div_dpath.sv
src/imuldiv_div_ctrl.sv
src/imuldiv_mul_iterative.sv
src/imuldiv_unit.sv
test/imuldiv_unit_tb.sv

// ==== src/imuldiv_div_ctrl.sv ====
//--------------------------------------------------------------------
// divider control FSM
// idle, calc and done states driving the datapath and val/rdy
//--------------------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_div_ctrl
  import imuldiv_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  input  logic [1:0] req_fn,
  input  logic       req_val,
  input  logic       resp_rdy,

  // status from the datapath
  input  logic       sub_neg,
  input  logic       counter_is_zero,

  output logic       req_rdy,
  output logic       resp_val,

  // datapath controls
  output logic       a_en,
  output logic       b_en,
  output logic       a_mux_sel,
  output logic       cntr_mux_sel,
  output logic       sign_en,
  output logic       is_signed
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_calc = 2'd1;
  localparam logic [1:0] st_done = 2'd2;

  logic [1:0] state;
  logic [1:0] state_next;
  logic       accept;
  logic       send;

  assign accept = req_val && req_rdy;
  assign send   = resp_val && resp_rdy;

  //------------------------------------------------------------------
  // state register
  //------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (accept) state_next = st_calc;
      // last step runs on the edge that leaves calc
      st_calc: if (counter_is_zero) state_next = st_done;
      st_done: if (send) state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  //------------------------------------------------------------------
  // outputs
  //------------------------------------------------------------------

  always_comb begin
    req_rdy      = (state == st_idle);
    resp_val     = (state == st_done);
    // load operands, signs and counter on acceptance
    a_en         = accept || (state == st_calc);
    b_en         = accept;
    sign_en      = accept;
    a_mux_sel    = (state == st_calc);
    cntr_mux_sel = (state == st_calc);
    // decoded only while loading, the datapath keeps the signs
    is_signed    = accept && imuldiv_is_signed(req_fn);
  end

  // response is held under back-pressure
  resp_held_a: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val);

  // operands were loaded before the first step
  sub_known_a: assert property (@(posedge clk) disable iff (reset)
    (state == st_calc) |-> !$isunknown(sub_neg));

endmodule

// ==== src/imuldiv_div_dpath.sv ====
//--------------------------------------------------------------------
// restoring divider datapath
// operand magnitudes, shift-subtract register, step counter, sign fix-up
//--------------------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_div_dpath
  import imuldiv_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,

  input  logic [IMULDIV_W-1:0] req_a,
  input  logic [IMULDIV_W-1:0] req_b,

  // from the control FSM
  input  logic                 a_en,
  input  logic                 b_en,
  input  logic                 a_mux_sel,
  input  logic                 cntr_mux_sel,
  input  logic                 sign_en,
  input  logic                 is_signed,

  // to the control FSM
  output logic                 sub_neg,
  output logic                 counter_is_zero,

  output imuldiv_result_u      result
);

  // remainder in [63:32], quotient grows in from bit 0
  logic [2*IMULDIV_W:0]   a_reg;
  // divisor parked in [63:32]
  logic [2*IMULDIV_W:0]   b_reg;
  logic [4:0]             counter;
  logic                   quot_neg;
  logic                   rem_neg;

  logic [IMULDIV_W-1:0]   a_mag;
  logic [IMULDIV_W-1:0]   b_mag;
  logic [2*IMULDIV_W:0]   a_shift;
  logic [2*IMULDIV_W:0]   diff;
  logic [2*IMULDIV_W:0]   a_step;
  logic [2*IMULDIV_W:0]   a_next;
  logic [4:0]             counter_next;
  logic [IMULDIV_W-1:0]   quot_mag;
  logic [IMULDIV_W-1:0]   rem_mag;

  //------------------------------------------------------------------
  // operand load
  //------------------------------------------------------------------

  // magnitudes only for signed divide, 0x80000000 maps to itself
  assign a_mag = (is_signed && req_a[IMULDIV_W-1]) ? (~req_a + 1'b1) : req_a;
  assign b_mag = (is_signed && req_b[IMULDIV_W-1]) ? (~req_b + 1'b1) : req_b;

  //------------------------------------------------------------------
  // one restoring step
  //------------------------------------------------------------------

  assign a_shift = a_reg << 1;
  assign diff    = a_shift - b_reg;
  // borrow out of the trial subtraction
  assign sub_neg = diff[2*IMULDIV_W];

  // restore on borrow and shift in 0, else keep difference and shift in 1
  assign a_step = sub_neg ? a_shift : {diff[2*IMULDIV_W:1], 1'b1};
  assign a_next = a_mux_sel ? a_step : {{(IMULDIV_W+1){1'b0}}, a_mag};

  // load steps-1 so the count hits zero on the last step
  assign counter_next    = cntr_mux_sel ? (counter - 5'd1) : 5'(IMULDIV_STEPS - 1);
  assign counter_is_zero = (counter == 5'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= 5'd0;
    end else if (a_en) begin
      counter <= counter_next;
    end
  end

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
    if (b_en) begin
      b_reg <= {1'b0, b_mag, {IMULDIV_W{1'b0}}};
    end
    // result signs come from the raw operands
    if (sign_en) begin
      quot_neg <= is_signed && (req_a[IMULDIV_W-1] ^ req_b[IMULDIV_W-1]);
      rem_neg  <= is_signed && req_a[IMULDIV_W-1];
    end
  end

  //------------------------------------------------------------------
  // sign fix-up and packing
  //------------------------------------------------------------------

  assign quot_mag = a_reg[IMULDIV_W-1:0];
  assign rem_mag  = a_reg[2*IMULDIV_W-1:IMULDIV_W];

  always_comb begin
    // quotient negated on differing signs
    result.divres.quot = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
    // remainder follows the dividend
    result.divres.rem  = rem_neg ? (~rem_mag + 1'b1) : rem_mag;
  end

endmodule

// ==== src/imuldiv_mul_iterative.sv ====
//--------------------------------------------------------------------
// iterative shift-add multiplier
// 32 steps over operand magnitudes, then a sign fix-up of the product
//--------------------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_mul_iterative
  import imuldiv_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,

  input  logic [IMULDIV_W-1:0] req_a,
  input  logic [IMULDIV_W-1:0] req_b,
  input  logic                 req_val,
  output logic                 req_rdy,

  output imuldiv_result_u      result,
  output logic                 resp_val,
  input  logic                 resp_rdy
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_calc = 2'd1;
  localparam logic [1:0] st_done = 2'd2;

  logic [1:0]             state;
  logic [4:0]             counter;

  // shifted multiplicand, multiplier and running sum
  logic [2*IMULDIV_W-1:0] mcand;
  logic [IMULDIV_W-1:0]   mplier;
  logic [2*IMULDIV_W-1:0] acc;
  logic                   prod_neg;

  logic [IMULDIV_W-1:0]   a_mag;
  logic [IMULDIV_W-1:0]   b_mag;
  logic                   accept;
  logic                   send;

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);
  assign accept   = req_val && req_rdy;
  assign send     = resp_val && resp_rdy;

  // multiply is always signed
  assign a_mag = req_a[IMULDIV_W-1] ? (~req_a + 1'b1) : req_a;
  assign b_mag = req_b[IMULDIV_W-1] ? (~req_b + 1'b1) : req_b;

  //------------------------------------------------------------------
  // FSM and step counter
  //------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_idle;
      counter <= 5'd0;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state   <= st_calc;
            counter <= 5'(IMULDIV_STEPS - 1);
          end
        end
        st_calc: begin
          // counter parks at zero on the way out
          if (counter == 5'd0) begin
            state <= st_done;
          end else begin
            counter <= counter - 5'd1;
          end
        end
        st_done: if (send) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  //------------------------------------------------------------------
  // shift-add datapath
  //------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      mcand    <= {{IMULDIV_W{1'b0}}, a_mag};
      mplier   <= b_mag;
      acc      <= '0;
      prod_neg <= req_a[IMULDIV_W-1] ^ req_b[IMULDIV_W-1];
    end else if (state == st_calc) begin
      // add partial product for the current multiplier bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // magnitude product fits in 63 bits so negation is exact
  assign result.product = prod_neg ? (~acc + 1'b1) : acc;

  // each calc cycle moves the counter down by one, or leaves calc
  cntr_no_wrap_a: assert property (@(posedge clk) disable iff (reset)
    (state == st_calc) |=> (state != st_calc) || (counter == $past(counter) - 5'd1));

endmodule

// ==== src/imuldiv_pkg.sv ====
//--------------------------------------------------------------------
// imuldiv shared definitions
// function codes, operand widths and the two-way result word
//--------------------------------------------------------------------
package imuldiv_pkg;

  //------------------------------------------------------------------
  // request function codes
  //------------------------------------------------------------------

  // full 64-bit signed product
  localparam logic [1:0] IMULDIV_FN_MUL  = 2'd0;
  // signed quotient and remainder
  localparam logic [1:0] IMULDIV_FN_DIV  = 2'd1;
  // unsigned quotient and remainder
  localparam logic [1:0] IMULDIV_FN_DIVU = 2'd2;

  //------------------------------------------------------------------
  // widths
  //------------------------------------------------------------------

  // operand width, result is twice this
  localparam int IMULDIV_W = 32;
  // one result bit per step in both engines
  localparam int IMULDIV_STEPS = 32;

  //------------------------------------------------------------------
  // result word
  //------------------------------------------------------------------

  // divide view, remainder in the upper half
  typedef struct packed {
    logic [IMULDIV_W-1:0] rem;
    logic [IMULDIV_W-1:0] quot;
  } imuldiv_divres_t;

  // same 64 bits read as a product or as rem/quot
  typedef union packed {
    logic signed [2*IMULDIV_W-1:0] product;
    imuldiv_divres_t               divres;
  } imuldiv_result_u;

  // true when the operands of fn are two's complement
  function automatic logic imuldiv_is_signed(input logic [1:0] fn);
    return (fn == IMULDIV_FN_MUL) || (fn == IMULDIV_FN_DIV);
  endfunction

endpackage

// ==== src/imuldiv_unit.sv ====
//--------------------------------------------------------------------
// integer multiply/divide unit
// steers one request at a time to the divider or multiplier
//--------------------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_unit
  import imuldiv_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,

  input  logic [1:0]           req_fn,
  input  logic [IMULDIV_W-1:0] req_a,
  input  logic [IMULDIV_W-1:0] req_b,
  input  logic                 req_val,
  output logic                 req_rdy,

  output imuldiv_result_u      resp_result,
  output logic                 resp_val,
  input  logic                 resp_rdy
);

  // request in flight, and whether the divider took it
  logic busy;
  logic owner_div;
  logic sel_div;

  logic div_req_val;
  logic div_req_rdy;
  logic div_resp_val;
  logic div_resp_rdy;
  imuldiv_result_u div_result;

  logic mul_req_val;
  logic mul_req_rdy;
  logic mul_resp_val;
  logic mul_resp_rdy;
  imuldiv_result_u mul_result;

  // divider control to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic cntr_mux_sel;
  logic sign_en;
  logic is_signed;
  logic sub_neg;
  logic counter_is_zero;

  //------------------------------------------------------------------
  // request steering
  //------------------------------------------------------------------

  assign sel_div     = (req_fn != IMULDIV_FN_MUL);
  assign div_req_val = req_val && !busy && sel_div;
  assign mul_req_val = req_val && !busy && !sel_div;
  assign req_rdy     = !busy && (sel_div ? div_req_rdy : mul_req_rdy);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      owner_div <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy      <= 1'b1;
      owner_div <= sel_div;
    end else if (resp_val && resp_rdy) begin
      busy      <= 1'b0;
    end
  end

  //------------------------------------------------------------------
  // response mux, only the owner sees resp_rdy
  //------------------------------------------------------------------

  assign resp_val     = owner_div ? div_resp_val : mul_resp_val;
  assign resp_result  = owner_div ? div_result : mul_result;
  assign div_resp_rdy = resp_rdy && busy && owner_div;
  assign mul_resp_rdy = resp_rdy && busy && !owner_div;

  imuldiv_div_ctrl div_ctrl_i (
    .clk             (clk),
    .reset           (reset),
    .req_fn          (req_fn),
    .req_val         (div_req_val),
    .resp_rdy        (div_resp_rdy),
    .sub_neg         (sub_neg),
    .counter_is_zero (counter_is_zero),
    .req_rdy         (div_req_rdy),
    .resp_val        (div_resp_val),
    .a_en            (a_en),
    .b_en            (b_en),
    .a_mux_sel       (a_mux_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en),
    .is_signed       (is_signed)
  );

  imuldiv_div_dpath div_dpath_i (
    .clk             (clk),
    .reset           (reset),
    .req_a           (req_a),
    .req_b           (req_b),
    .a_en            (a_en),
    .b_en            (b_en),
    .a_mux_sel       (a_mux_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en),
    .is_signed       (is_signed),
    .sub_neg         (sub_neg),
    .counter_is_zero (counter_is_zero),
    .result          (div_result)
  );

  imuldiv_mul_iterative mul_i (
    .clk      (clk),
    .reset    (reset),
    .req_a    (req_a),
    .req_b    (req_b),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .result   (mul_result),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  // an engine only answers a request this level handed it
  resp_busy_a: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> busy);

endmodule

// ==== test/imuldiv_input.txt ====
# name fn a b expected stall; fn 0 mul, 1 signed div, 2 unsigned div; hex except stall
# expected is the 64-bit product, or {rem, quot}; stall -1 draws a random stall
mul_pos       0 00000007 00000006 000000000000002a 0
mul_neg       0 fffffff9 fffffffa 000000000000002a 0
mul_mixed     0 00000003 fffffffb fffffffffffffff1 2
mul_max_max   0 7fffffff 7fffffff 3fffffff00000001 0
mul_min_min   0 80000000 80000000 4000000000000000 0
mul_min_one   0 80000000 00000001 ffffffff80000000 5
mul_min_max   0 80000000 7fffffff c000000080000000 0
mul_zero      0 00000000 deadbeef 0000000000000000 0
mul_shift     0 00010000 00010000 0000000100000000 -1
mul_negone    0 ffffffff ffffffff 0000000000000001 0
div_pos       1 00000064 00000007 000000020000000e 0
div_neg_a     1 ffffff9c 00000007 fffffffefffffff2 3
div_neg_b     1 00000064 fffffff9 00000002fffffff2 0
div_neg_both  1 ffffff9c fffffff9 fffffffe0000000e 0
div_min_neg1  1 80000000 ffffffff 0000000080000000 -1
div_min_two   1 80000000 00000002 00000000c0000000 0
div_min_seven 1 80000000 00000007 fffffffeedb6db6e 7
div_small     1 00000003 0000000a 0000000300000000 0
divu_ones     2 ffffffff 00000010 0000000f0fffffff 0
divu_top      2 80000000 80000001 8000000000000000 1
divu_both     2 fffffffe 80000000 7ffffffe00000001 0
divu_hex      2 deadbeef 00010000 0000beef0000dead -1
div0_pos      1 00000005 00000000 00000005ffffffff 0
div0_neg      1 fffffffb 00000000 fffffffb00000001 4
divu0_top     2 80000000 00000000 80000000ffffffff 0
mul_after     0 fffffffe 00000003 fffffffffffffffa 0

// ==== test/imuldiv_checks.svh ====
//--------------------------------------------------------------------
// testbench compare tasks and the LFSR step used for random stalls
//--------------------------------------------------------------------
`ifndef IMULDIV_CHECKS_SVH
`define IMULDIV_CHECKS_SVH

// whole 64-bit word read as a signed product
task automatic check_product(input string name, input imuldiv_result_u exp,
                             input imuldiv_result_u act);
  if (act.product !== exp.product) begin
    $display("[FAIL] %s product expected %h actual %h", name, exp.product, act.product);
    fail_count++;
  end
endtask

// quotient and remainder halves are reported on their own
task automatic check_divide(input string name, input imuldiv_result_u exp,
                            input imuldiv_result_u act);
  if (act.divres.quot !== exp.divres.quot) begin
    $display("[FAIL] %s quot expected %h actual %h", name, exp.divres.quot, act.divres.quot);
    fail_count++;
  end
  if (act.divres.rem !== exp.divres.rem) begin
    $display("[FAIL] %s rem expected %h actual %h", name, exp.divres.rem, act.divres.rem);
    fail_count++;
  end
endtask

// handshake levels
task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("[FAIL] %s expected %b actual %b", name, exp, act);
    fail_count++;
  end
endtask

// cycle distances
task automatic check_count(input string name, input int exp, input int act);
  if (act != exp) begin
    $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
    fail_count++;
  end
endtask

// 16-bit Galois LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

`endif

// ==== test/imuldiv_unit_tb.sv ====
//--------------------------------------------------------------------
// imuldiv unit testbench
// file-driven requests, stalled responses, latency and result checks
//--------------------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_unit_tb
  import imuldiv_pkg::*;
();

  // accepting edge to first edge that sees resp_val
  localparam int LATENCY    = 33;
  localparam int WAIT_LIMIT = 200;

  logic                 clk;
  logic                 reset;
  logic [1:0]           req_fn;
  logic [IMULDIV_W-1:0] req_a;
  logic [IMULDIV_W-1:0] req_b;
  logic                 req_val;
  logic                 req_rdy;
  imuldiv_result_u      resp_result;
  logic                 resp_val;
  logic                 resp_rdy;

  int          fail_count    = 0;
  int          timeout_count = 0;
  int          test_count    = 0;
  // rising edges seen so far
  int          cycle         = 0;
  logic [15:0] lfsr;
  bit          aborted       = 1'b0;

  `include "imuldiv_checks.svh"

  imuldiv_unit imuldiv_unit_i (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // stall length from four LFSR bits
  function automatic int random_stall();
    int n;
    int i;
    n = 0;
    for (i = 0; i < 4; i++) begin
      n = (n << 1) | lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
    return n;
  endfunction

  // product view for multiply, rem/quot view for both divides
  task automatic compare_result(input string name, input logic [1:0] fn,
                                input imuldiv_result_u exp,
                                input imuldiv_result_u act);
    if (fn == IMULDIV_FN_MUL) begin
      check_product(name, exp, act);
    end else begin
      check_divide(name, exp, act);
    end
  endtask

  //------------------------------------------------------------------
  // one request, one response; called 2 ns after a rising edge
  // stall 0 keeps resp_rdy high for the whole request
  //------------------------------------------------------------------
  task automatic run_test(input string name, input logic [1:0] fn,
                          input logic [31:0] a, input logic [31:0] b,
                          input imuldiv_result_u exp, input int stall);
    int waited;
    int t_accept;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    // outputs are sampled at the falling edge
    waited = 0;
    @(negedge clk);
    while (!req_rdy && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (!req_rdy) begin
      $display("timeout in %s: the unit never became ready for a request", name);
      timeout_count++;
      aborted = 1'b1;
      return;
    end
    t_accept = cycle + 1;
    @(posedge clk);
    #2;
    req_val = 1'b0;
    // scribble the payload, engines must not look at it while busy
    req_a = ~a;
    req_b = ~b;
    // no back-pressure, the response goes on its first edge
    if (stall == 0) begin
      resp_rdy = 1'b1;
    end
    waited = 0;
    @(negedge clk);
    while (!resp_val && waited < WAIT_LIMIT) begin
      check_flag({name, " req_rdy while busy"}, 1'b0, req_rdy);
      waited++;
      @(negedge clk);
    end
    if (!resp_val) begin
      $display("timeout in %s: no response arrived", name);
      timeout_count++;
      aborted = 1'b1;
      return;
    end
    check_count({name, " latency"}, LATENCY, cycle + 1 - t_accept);
    check_flag({name, " req_rdy with response"}, 1'b0, req_rdy);
    compare_result(name, fn, exp, resp_result);
    if (stall > 0) begin
      // back-pressure for stall edges, everything must hold still
      repeat (stall - 1) begin
        @(negedge clk);
        check_flag({name, " resp_val under stall"}, 1'b1, resp_val);
        check_flag({name, " req_rdy under stall"}, 1'b0, req_rdy);
        compare_result({name, " held"}, fn, exp, resp_result);
      end
      @(posedge clk);
      #2;
      resp_rdy = 1'b1;
      @(negedge clk);
      check_flag({name, " resp_val at handshake"}, 1'b1, resp_val);
      check_flag({name, " req_rdy at handshake"}, 1'b0, req_rdy);
      compare_result({name, " held"}, fn, exp, resp_result);
    end
    @(posedge clk);
    #2;
    resp_rdy = 1'b0;
  endtask

  //------------------------------------------------------------------
  // main sequence
  //------------------------------------------------------------------
  initial begin
    int              fd;
    int              n;
    string           line;
    string           name;
    logic [1:0]      fn;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [63:0]     exp;
    int              stall;
    imuldiv_result_u exp_u;
    reset    = 1'b1;
    req_fn   = IMULDIV_FN_MUL;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    lfsr     = 16'd489;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    check_flag("after_reset req_rdy", 1'b1, req_rdy);
    check_flag("after_reset resp_val", 1'b0, resp_val);
    @(posedge clk);
    #2;
    fd = $fopen("test/imuldiv_input.txt", "r");
    if (fd == 0) begin
      $display("could not open test/imuldiv_input.txt");
      fail_count++;
    end else begin
      while (!aborted && !$feof(fd)) begin
        if ($fgets(line, fd) == 0) break;
        // skip comments and blank lines
        if (line.len() < 2 || line[0] == "#") continue;
        n = $sscanf(line, "%s %h %h %h %h %d", name, fn, a, b, exp, stall);
        if (n != 6) begin
          $display("malformed line in input file: %s", line);
          fail_count++;
          continue;
        end
        if (stall < 0) stall = random_stall();
        exp_u = exp;
        test_count++;
        run_test(name, fn, a, b, exp_u, stall);
      end
      $fclose(fd);
    end
    $display("tests %0d, mismatches %0d, timeouts %0d", test_count, fail_count, timeout_count);
    if (fail_count == 0 && timeout_count == 0 && test_count > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
